/* source/rsc_pkg.sv */
package rsc_pkg;

   // ========================================
   // Code symbol and trellis types
   // ========================================

   // Bit 1 carries parity, bit 0 the systematic bit.
   typedef logic [1:0] sym_t;

   typedef logic [2:0] state_t;

   typedef enum logic
   {
      ENC_DATA,
      ENC_TAIL
   } enc_phase_e;

   // One termination symbol per state bit.
   localparam int TAIL_LEN = $bits(state_t);

   // ========================================
   // Trellis functions
   // ========================================

   function automatic state_t rsc_next_state(input state_t s, input logic b);
      return {b ^ s[1] ^ s[0], s[2], s[1]};
   endfunction

   function automatic logic rsc_parity(input state_t s, input logic b);
      return b ^ s[2] ^ s[1];
   endfunction

   // Input that cancels the feedback and shifts a zero into bit 2.
   function automatic logic rsc_feedback(input state_t s);
      return s[1] ^ s[0];
   endfunction

endpackage

/* source/rsc_encoder.sv */
module rsc_encoder
   import rsc_pkg::*;
#(
   parameter int FRAME_LEN  = 16,
   parameter int FIFO_DEPTH = 4
)
(
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   input  logic in_data,
   input  sym_t in_fault,
   input  logic credit_ret,
   output logic in_ready,
   output logic push,
   output sym_t push_sym
);

   localparam int BIT_W  = $clog2(FRAME_LEN + 1);
   localparam int TAIL_W = $clog2(TAIL_LEN + 1);
   localparam int CRD_W  = $clog2(FIFO_DEPTH + 1);

   enc_phase_e        phase;
   state_t            state;
   logic [BIT_W-1:0]  bit_cnt;
   logic [TAIL_W-1:0] tail_cnt;
   logic [CRD_W-1:0]  credits;

   logic have_credit;
   logic accept;
   logic tail_go;
   logic spend;
   logic enc_bit;
   sym_t enc_sym;
   logic last_bit;
   logic last_tail;

   assign have_credit = (credits != '0);
   assign in_ready    = (phase == ENC_DATA) && have_credit;
   assign accept      = in_valid && in_ready;
   assign tail_go     = (phase == ENC_TAIL) && have_credit;
   assign spend       = accept || tail_go;

   // Tail symbols take the feedback value as input.
   assign enc_bit   = (phase == ENC_TAIL) ? rsc_feedback(state) : in_data;
   assign enc_sym   = {rsc_parity(state, enc_bit), enc_bit};
   assign last_bit  = (bit_cnt == BIT_W'(FRAME_LEN - 1));
   assign last_tail = (tail_cnt == TAIL_W'(TAIL_LEN - 1));

   // ========================================
   // Phase FSM and trellis state
   // ========================================

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         phase    <= ENC_DATA;
         state    <= '0;
         bit_cnt  <= '0;
         tail_cnt <= '0;
      end
      else if (accept)
      begin
         state <= rsc_next_state(state, enc_bit);
         if (last_bit)
         begin
            bit_cnt <= '0;
            phase   <= ENC_TAIL;
         end
         else
            bit_cnt <= bit_cnt + 1'b1;
      end
      else if (tail_go)
      begin
         state <= rsc_next_state(state, enc_bit);
         if (last_tail)
         begin
            tail_cnt <= '0;
            phase    <= ENC_DATA;
         end
         else
            tail_cnt <= tail_cnt + 1'b1;
      end
   end

   // ========================================
   // Symbol output and credits
   // ========================================

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         push <= 1'b0;
      else
         push <= spend;
   end

   // Channel errors only touch data symbols.
   always_ff @(posedge clk)
   begin
      if (spend)
         push_sym <= enc_sym ^ (accept ? in_fault : sym_t'('0));
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         credits <= CRD_W'(FIFO_DEPTH);
      else
         credits <= credits - CRD_W'(spend) + CRD_W'(credit_ret);
   end

   a_credit_bound: assert property (@(posedge clk) disable iff (!rst)
      credits <= CRD_W'(FIFO_DEPTH));

   a_tail_closed: assert property (@(posedge clk) disable iff (!rst)
      $fell(phase == ENC_TAIL) |-> (state == '0));

endmodule

/* source/credit_fifo.sv */
module credit_fifo
   import rsc_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
)
(
   input  logic clk,
   input  logic rst,
   input  logic push,
   input  sym_t push_sym,
   input  logic pop,
   output logic not_empty,
   output sym_t head_sym,
   output logic credit_ret
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   sym_t             mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_pop;

   // Pointers wrap at the depth, which need not be a power of two.
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      return p + 1'b1;
   endfunction

   assign not_empty  = (count != '0);
   assign full       = (count == CNT_W'(FIFO_DEPTH));
   assign do_pop     = pop && not_empty;
   assign head_sym   = mem[rd_ptr];

   // Each read frees a slot, so it goes straight back as a credit.
   assign credit_ret = do_pop;

   // ========================================
   // Storage and pointers
   // ========================================

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_sym;
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         count <= count + CNT_W'(push) - CNT_W'(do_pop);
      end
   end

   // The credit loop upstream keeps the buffer from overflowing.
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
      !(push && full));

   a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
      !(pop && !not_empty));

endmodule

/* source/parity_checker.sv */
module parity_checker
   import rsc_pkg::*;
#(
   parameter int FRAME_LEN = 16
)
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                not_empty,
   input  sym_t                                head_sym,
   input  logic                                out_ready,
   output logic                                pop,
   output logic                                out_valid,
   output logic                                out_data,
   output logic                                out_parity_err,
   output logic                                frame_done,
   output logic [$clog2(FRAME_LEN + TAIL_LEN):0] frame_errs,
   output logic                                frame_term_ok
);

   localparam int SYM_TOTAL = FRAME_LEN + TAIL_LEN;
   localparam int POS_W     = $clog2(SYM_TOTAL);
   localparam int ERR_W     = $clog2(SYM_TOTAL) + 1;

   state_t           state;
   state_t           next_state;
   logic [POS_W-1:0] pos;
   logic [ERR_W-1:0] err_cnt;
   logic [ERR_W-1:0] err_sum;
   logic             rx_sys;
   logic             rx_par;
   logic             mismatch;
   logic             is_data;
   logic             is_last;
   logic             out_free;

   assign rx_sys     = head_sym[0];
   assign rx_par     = head_sym[1];
   assign mismatch   = rx_par ^ rsc_parity(state, rx_sys);
   assign next_state = rsc_next_state(state, rx_sys);
   assign is_data    = (pos < POS_W'(FRAME_LEN));
   assign is_last    = (pos == POS_W'(SYM_TOTAL - 1));
   assign err_sum    = err_cnt + ERR_W'(mismatch);

   // Tail symbols have no output slot to wait for.
   assign out_free = !out_valid || out_ready;
   assign pop      = not_empty && (out_free || !is_data);

   // ========================================
   // Re-encoding trellis and frame position
   // ========================================

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state   <= '0;
         pos     <= '0;
         err_cnt <= '0;
      end
      else if (pop)
      begin
         if (is_last)
         begin
            state   <= '0;
            pos     <= '0;
            err_cnt <= '0;
         end
         else
         begin
            state   <= next_state;
            pos     <= pos + 1'b1;
            err_cnt <= err_sum;
         end
      end
   end

   // ========================================
   // Data output and frame report
   // ========================================

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         out_valid <= 1'b0;
      else if (pop && is_data)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (pop && is_data)
      begin
         out_data       <= rx_sys;
         out_parity_err <= mismatch;
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         frame_done <= 1'b0;
      else
         frame_done <= pop && is_last;
   end

   // A clean frame leaves the trellis back in state zero.
   always_ff @(posedge clk)
   begin
      if (pop && is_last)
      begin
         frame_errs    <= err_sum;
         frame_term_ok <= (next_state == '0);
      end
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rst)
      (out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_parity_err)));

endmodule

/* source/rsc_link_top.sv */
module rsc_link_top
   import rsc_pkg::*;
#(
   parameter int FRAME_LEN  = 16,
   parameter int FIFO_DEPTH = 4
)
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                in_valid,
   input  logic                                in_data,
   input  sym_t                                in_fault,
   output logic                                in_ready,
   input  logic                                out_ready,
   output logic                                out_valid,
   output logic                                out_data,
   output logic                                out_parity_err,
   output logic                                frame_done,
   output logic [$clog2(FRAME_LEN + TAIL_LEN):0] frame_errs,
   output logic                                frame_term_ok
);

   // Encoder to buffer.
   logic push;
   sym_t push_sym;
   logic credit_ret;

   // Buffer to checker.
   logic not_empty;
   sym_t head_sym;
   logic pop;

   rsc_encoder #(
      .FRAME_LEN  (FRAME_LEN),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) enc0 (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_fault   (in_fault),
      .credit_ret (credit_ret),
      .in_ready   (in_ready),
      .push       (push),
      .push_sym   (push_sym)
   );

   credit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) fifo0 (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_sym   (push_sym),
      .pop        (pop),
      .not_empty  (not_empty),
      .head_sym   (head_sym),
      .credit_ret (credit_ret)
   );

   parity_checker #(
      .FRAME_LEN (FRAME_LEN)
   ) chk0 (
      .clk            (clk),
      .rst            (rst),
      .not_empty      (not_empty),
      .head_sym       (head_sym),
      .out_ready      (out_ready),
      .pop            (pop),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .out_parity_err (out_parity_err),
      .frame_done     (frame_done),
      .frame_errs     (frame_errs),
      .frame_term_ok  (frame_term_ok)
   );

endmodule

/* test/tb_rsc_link.sv */
module tb_rsc_link
   import rsc_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int FRAME_LEN      = 16;
   localparam int FIFO_DEPTH     = 4;
   localparam int SYM_TOTAL      = FRAME_LEN + TAIL_LEN;
   localparam int N_FRAMES       = 12;
   localparam int TIMEOUT_CYCLES = 40 * SYM_TOTAL * N_FRAMES;
   localparam int STALL_LEN      = 24;
   localparam int STALL_PROBE    = 20;

   // Frame kinds.
   localparam int K_CLEAN  = 0;
   localparam int K_PARITY = 1;
   localparam int K_SYS    = 2;
   localparam int K_GAPS   = 3;
   localparam int K_STALL  = 4;

   logic                          clk;
   logic                          rst;
   logic                          in_valid;
   logic                          in_data;
   sym_t                          in_fault;
   logic                          in_ready;
   logic                          out_ready;
   logic                          out_valid;
   logic                          out_data;
   logic                          out_parity_err;
   logic                          frame_done;
   logic [$clog2(SYM_TOTAL):0]    frame_errs;
   logic                          frame_term_ok;

   logic exp_data_q [$];
   logic exp_err_q [$];
   int   exp_errs_q [$];
   logic exp_term_q [$];

   int   ready_mode;
   logic reset_done;
   logic stim_done;
   int   frames_seen;
   int   stall_run;
   int   stall_checks;
   int   cycle_count;

   rsc_link_top #(
      .FRAME_LEN  (FRAME_LEN),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut0 (
      .clk            (clk),
      .rst            (rst),
      .in_valid       (in_valid),
      .in_data        (in_data),
      .in_fault       (in_fault),
      .in_ready       (in_ready),
      .out_ready      (out_ready),
      .out_valid      (out_valid),
      .out_data       (out_data),
      .out_parity_err (out_parity_err),
      .frame_done     (frame_done),
      .frame_errs     (frame_errs),
      .frame_term_ok  (frame_term_ok)
   );

   // ========================================
   // Reporting
   // ========================================

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
                             $time, what, got, exp));
   endtask

   // ========================================
   // Reference model
   // ========================================

   // Encodes one frame with its tail, applies the channel faults, then
   // re-encodes on the received systematic bits as the receiver sees them.
   function automatic void model_frame(input logic [FRAME_LEN-1:0]   bits,
                                       input logic [2*FRAME_LEN-1:0] masks);
      sym_t   rx [SYM_TOTAL];
      state_t tx_state;
      state_t rx_state;
      logic   b;
      logic   mis;
      int     errs;
      tx_state = '0;
      for (int i = 0; i < SYM_TOTAL; i++)
      begin
         b     = (i < FRAME_LEN) ? bits[i] : rsc_feedback(tx_state);
         rx[i] = {rsc_parity(tx_state, b), b};
         if (i < FRAME_LEN)
            rx[i] = rx[i] ^ masks[2*i +: 2];
         tx_state = rsc_next_state(tx_state, b);
      end
      rx_state = '0;
      errs     = 0;
      for (int i = 0; i < SYM_TOTAL; i++)
      begin
         mis      = rx[i][1] ^ rsc_parity(rx_state, rx[i][0]);
         rx_state = rsc_next_state(rx_state, rx[i][0]);
         errs     = errs + int'(mis);
         if (i < FRAME_LEN)
         begin
            exp_data_q.push_back(rx[i][0]);
            exp_err_q.push_back(mis);
         end
      end
      exp_errs_q.push_back(errs);
      exp_term_q.push_back(rx_state == '0);
   endfunction

   // ========================================
   // Stimulus
   // ========================================

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic send_bit(input logic b, input sym_t m);
      logic took;
      in_valid = 1'b1;
      in_data  = b;
      in_fault = m;
      took     = 1'b0;
      while (!took)
      begin
         @(negedge clk);
         took = in_ready;
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      in_data  = 1'b0;
      in_fault = '0;
   endtask

   task automatic send_frame(input int kind);
      logic [FRAME_LEN-1:0]   bits;
      logic [2*FRAME_LEN-1:0] masks;
      int                     pos;
      masks = '0;
      for (int i = 0; i < FRAME_LEN; i++)
      begin
         bits[i] = 1'($urandom_range(0, 1));
         if (kind == K_GAPS && $urandom_range(0, 7) == 0)
            masks[2*i +: 2] = 2'($urandom_range(1, 3));
      end
      pos = $urandom_range(0, FRAME_LEN - 1);
      if (kind == K_PARITY)
         masks[2*pos +: 2] = 2'b10;
      else if (kind == K_SYS)
         masks[2*pos +: 2] = 2'b01;
      model_frame(bits, masks);
      // Gap frames also pause right at the frame boundary.
      if (kind == K_GAPS)
         idle_cycles($urandom_range(2, 8));
      for (int i = 0; i < FRAME_LEN; i++)
      begin
         if (kind == K_GAPS && $urandom_range(0, 3) == 0)
            idle_cycles($urandom_range(1, 4));
         send_bit(bits[i], masks[2*i +: 2]);
      end
   endtask

   function automatic int frame_kind(input int f);
      if (f < 3)
         return K_CLEAN;
      if (f < 5)
         return K_PARITY;
      if (f < 7)
         return K_SYS;
      if (f < 10)
         return K_GAPS;
      return K_STALL;
   endfunction

   initial
   begin
      void'($urandom(18908));
      rst          = 1'b0;
      in_valid     = 1'b0;
      in_data      = 1'b0;
      in_fault     = '0;
      out_ready    = 1'b1;
      ready_mode   = 0;
      reset_done   = 1'b0;
      stim_done    = 1'b0;
      frames_seen  = 0;
      stall_run    = 0;
      stall_checks = 0;
      repeat (16)
      begin
         @(posedge clk);
         #1;
         check_value("out_valid in reset", out_valid, 0);
         check_value("frame_done in reset", frame_done, 0);
      end
      rst = 1'b1;
      repeat (4)
      begin
         @(negedge clk);
         check_value("in_ready after reset", in_ready, 1);
         check_value("out_valid after reset", out_valid, 0);
         check_value("frame_done after reset", frame_done, 0);
      end
      @(posedge clk);
      #1;
      reset_done = 1'b1;
   end

   initial
   begin
      int kind;
      wait (reset_done);
      for (int f = 0; f < N_FRAMES; f++)
      begin
         kind       = frame_kind(f);
         ready_mode = (kind == K_GAPS) ? 1 : (kind == K_STALL) ? 2 : 0;
         send_frame(kind);
      end
      ready_mode = 0;
      stim_done  = 1'b1;
   end

   // Mode 1 stalls out_ready at random, mode 2 holds it low for long runs.
   initial
   begin
      wait (reset_done);
      forever
      begin
         @(posedge clk);
         #1;
         if (ready_mode == 2)
         begin
            out_ready = 1'b0;
            idle_cycles(STALL_LEN);
            out_ready = 1'b1;
            idle_cycles($urandom_range(0, 2));
         end
         else if (ready_mode == 1)
            out_ready = ($urandom_range(0, 3) != 0);
         else
            out_ready = 1'b1;
      end
   end

   // ========================================
   // Compare and timeout
   // ========================================

   initial
   begin
      wait (reset_done);
      while (!(stim_done && frames_seen == N_FRAMES && exp_data_q.size() == 0))
      begin
         @(negedge clk);
         if (out_valid && out_ready)
         begin
            if (exp_data_q.size() == 0)
               abort_run("An output bit appeared with no data bit left to expect.");
            check_value("out_data", out_data, exp_data_q.pop_front());
            check_value("out_parity_err", out_parity_err, exp_err_q.pop_front());
         end
         if (frame_done)
         begin
            if (exp_errs_q.size() == 0)
               abort_run("A frame report appeared with no frame left to expect.");
            check_value("frame_errs", frame_errs, exp_errs_q.pop_front());
            check_value("frame_term_ok", frame_term_ok, exp_term_q.pop_front());
            frames_seen++;
         end
         stall_run = out_ready ? 0 : stall_run + 1;
         if (stall_run == STALL_PROBE && in_valid)
         begin
            check_value("in_ready under back-pressure", in_ready, 0);
            stall_checks++;
         end
      end
      repeat (10)
      begin
         @(negedge clk);
         check_value("out_valid when idle", out_valid, 0);
         check_value("frame_done when idle", frame_done, 0);
      end
      if (stall_checks == 0)
      begin
         $display("Back-pressure never reached the input while data was offered.");
         $display("Simulation FAILED");
         $fatal(1, "no back-pressure seen");
      end
      else
      begin
         $display("Simulation PASSED");
         $finish;
      end
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      abort_run("Timeout: the link stalled and the run did not finish in time.");
   end

endmodule

/* compile.f */
source/rsc_pkg.sv
source/rsc_encoder.sv
source/credit_fifo.sv
source/parity_checker.sv
source/rsc_link_top.sv
test/tb_rsc_link.sv

/* Bender.yml */
package:
  name: rsc_link

sources:
  - source/rsc_pkg.sv
  - source/rsc_encoder.sv
  - source/credit_fifo.sv
  - source/parity_checker.sv
  - source/rsc_link_top.sv
  - target: test
    files:
      - test/tb_rsc_link.sv
